//--- agc_pkg.sv
`default_nettype none

package agc_pkg;

  // Datapath widths
  localparam int WORD_W      = 15;
  localparam int SOFT_ADDR_W = 12;
  localparam int ROM_ADDR_W  = 14;
  localparam int RAM_ADDR_W  = 11;
  localparam int BANK_W      = 3;

  typedef logic [WORD_W-1:0]      word_t;
  typedef logic [SOFT_ADDR_W-1:0] soft_addr_t;
  typedef logic [ROM_ADDR_W-1:0]  rom_addr_t;
  typedef logic [RAM_ADDR_W-1:0]  ram_addr_t;
  typedef logic [BANK_W-1:0]      bank_t;

  // Central register selects
  typedef enum logic [3:0] {
    A,
    L,
    Q,
    EB,
    FB,
    BB,
    ZERO,
    CYR,
    SR,
    CYL,
    SL,
    TIME1,
    TIME2
  } reg_sel_t;

  // Software memory map, all octal
  localparam soft_addr_t FIXED_ROM_BASE  = 12'o4000;
  localparam soft_addr_t ROM_SPACE_BASE  = 12'o2000;
  localparam soft_addr_t RAM_BANKED_BASE = 12'o1400;

  // Physical bank geometry
  localparam rom_addr_t ROM_BANK_SIZE        = 14'o2000;
  localparam ram_addr_t RAM_BANK_SIZE        = 11'o0400;
  localparam ram_addr_t RAM_HIGH_BANK_OFFSET = 11'o2000;

  // Bank sizes are powers of two so bank numbers shift into place
  localparam int ROM_BANK_SHIFT = $clog2(ROM_BANK_SIZE);
  localparam int RAM_BANK_SHIFT = $clog2(RAM_BANK_SIZE);

  // Where the bank fields sit in a data word
  localparam int EB_LSB = 9;
  localparam int FB_LSB = 12;

  localparam word_t EB_MASK = word_t'({BANK_W{1'b1}}) << EB_LSB;
  localparam word_t FB_MASK = word_t'({BANK_W{1'b1}}) << FB_LSB;

endpackage

`default_nettype wire

//--- agc_rom_translate.sv
`default_nettype none

module agc_rom_translate
  import agc_pkg::*;
(
  input  soft_addr_t addr_soft,
  input  bank_t      bits_fb,
  output rom_addr_t  addr_rom
);

  logic      is_fixed;
  rom_addr_t fixed_addr;
  rom_addr_t bank_offset;
  rom_addr_t banked_addr;

  // Fixed-fixed ROM lives at the top of software space
  assign is_fixed   = addr_soft >= FIXED_ROM_BASE;
  assign fixed_addr = rom_addr_t'(addr_soft - FIXED_ROM_BASE);

  // FB selects a bank by shifting into place
  assign bank_offset = rom_addr_t'(bits_fb) << ROM_BANK_SHIFT;

  assign banked_addr = rom_addr_t'(addr_soft)
                     + rom_addr_t'(ROM_SPACE_BASE)
                     + bank_offset;

  assign addr_rom = is_fixed ? fixed_addr : banked_addr;

endmodule

`default_nettype wire

//--- agc_ram_translate.sv
`default_nettype none

module agc_ram_translate
  import agc_pkg::*;
(
  input  soft_addr_t addr_soft,
  input  bank_t      bits_eb,
  output ram_addr_t  addr_ram
);

  logic      is_fixed;
  ram_addr_t addr_low;
  ram_addr_t low_offset;
  ram_addr_t bank_offset;

  // Unswitched erasable sits below the banked window
  assign is_fixed = addr_soft < RAM_BANKED_BASE;
  assign addr_low = ram_addr_t'(addr_soft);

  // Low banks from EB[1:0]
  assign low_offset = ram_addr_t'(bits_eb[1:0]) << RAM_BANK_SHIFT;

  // EB[2] jumps to the high bank instead
  assign bank_offset = bits_eb[2] ? RAM_HIGH_BANK_OFFSET : low_offset;

  // Sum wraps at 11 bits
  assign addr_ram = is_fixed ? addr_low : addr_low + bank_offset;

endmodule

`default_nettype wire

//--- agc_addr_translate.sv
`default_nettype none

module agc_addr_translate
  import agc_pkg::*;
(
  input  soft_addr_t addr_pc,
  input  soft_addr_t addr_r,
  input  soft_addr_t addr_w,
  input  bank_t      bits_eb,
  input  bank_t      bits_fb,
  input  logic       ram_we_req,
  output rom_addr_t  addr_rom_pc,
  output rom_addr_t  addr_rom_r,
  output ram_addr_t  addr_ram_r,
  output ram_addr_t  addr_ram_w,
  output logic       ram_we
);

  rom_addr_t rom_r;
  ram_addr_t ram_r;
  logic      r_in_rom;

  // Instruction fetch always targets ROM
  agc_rom_translate u_rom_pc (
    .addr_soft (addr_pc),
    .bits_fb   (bits_fb),
    .addr_rom  (addr_rom_pc)
  );

  // Read path computes both sides, then picks one
  agc_rom_translate u_rom_r (
    .addr_soft (addr_r),
    .bits_fb   (bits_fb),
    .addr_rom  (rom_r)
  );

  agc_ram_translate u_ram_r (
    .addr_soft (addr_r),
    .bits_eb   (bits_eb),
    .addr_ram  (ram_r)
  );

  agc_ram_translate u_ram_w (
    .addr_soft (addr_w),
    .bits_eb   (bits_eb),
    .addr_ram  (addr_ram_w)
  );

  assign r_in_rom = addr_r >= ROM_SPACE_BASE;

  // Side not addressed parks on its lowest valid address
  assign addr_rom_r = r_in_rom ? rom_r : rom_addr_t'(ROM_SPACE_BASE);
  assign addr_ram_r = r_in_rom ? '0 : ram_r;

  // ROM is read-only
  assign ram_we = ram_we_req && (addr_w < ROM_SPACE_BASE);

endmodule

`default_nettype wire

//--- agc_register_file.sv
`default_nettype none

module agc_register_file
  import agc_pkg::*;
(
  input  logic     clk,
  input  logic     rst_l,
  input  logic     wr1_en,
  input  logic     wr2_en,
  input  reg_sel_t wr1_sel,
  input  reg_sel_t wr2_sel,
  input  reg_sel_t rs1_sel,
  input  reg_sel_t rs2_sel,
  input  word_t    wr1_data,
  input  word_t    wr2_data,
  output word_t    rs1_data,
  output word_t    rs2_data,
  output bank_t    bits_eb,
  output bank_t    bits_fb
);

  // Word as the target register will hold it after the write
  function automatic word_t post_write(reg_sel_t sel, word_t d);
    word_t img;
    img = '0;
    case (sel)
      A, L, Q, TIME1, TIME2: img = d;
      // Editing registers
      CYR: img = {d[0], d[WORD_W-1:1]};
      SR:  img = {d[WORD_W-1], d[WORD_W-1:1]};
      CYL: img = {d[WORD_W-2:0], d[WORD_W-1]};
      SL:  img = {d[WORD_W-2:0], 1'b0};
      // Bank registers only keep their own fields
      EB:  img = d & EB_MASK;
      FB:  img = d & FB_MASK;
      BB:  img = d & (EB_MASK | FB_MASK);
      default: img = '0;
    endcase
    return img;
  endfunction

  word_t reg_a;
  word_t reg_l;
  word_t reg_q;
  word_t reg_cyr;
  word_t reg_sr;
  word_t reg_cyl;
  word_t reg_sl;
  word_t reg_time1;
  word_t reg_time2;
  bank_t eb_q;
  bank_t fb_q;

  // Both ports as arrays, index 1 is port 2
  logic [1:0] wr_en;
  reg_sel_t   wr_sel [2];
  word_t      wr_img [2];
  reg_sel_t   rs_sel [2];
  word_t      rs_data [2];

  assign wr_en     = {wr2_en, wr1_en};
  assign wr_sel[0] = wr1_sel;
  assign wr_sel[1] = wr2_sel;
  assign wr_img[0] = post_write(wr1_sel, wr1_data);
  assign wr_img[1] = post_write(wr2_sel, wr2_data);
  assign rs_sel[0] = rs1_sel;
  assign rs_sel[1] = rs2_sel;

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      reg_a     <= '0;
      reg_l     <= '0;
      reg_q     <= '0;
      reg_cyr   <= '0;
      reg_sr    <= '0;
      reg_cyl   <= '0;
      reg_sl    <= '0;
      reg_time1 <= '0;
      reg_time2 <= '0;
      eb_q      <= '0;
      fb_q      <= '0;
    end else begin
      // Port 2 goes last, so it wins a shared target
      for (int p = 0; p < 2; p++) begin
        if (wr_en[p]) begin
          case (wr_sel[p])
            A:     reg_a     <= wr_img[p];
            L:     reg_l     <= wr_img[p];
            Q:     reg_q     <= wr_img[p];
            CYR:   reg_cyr   <= wr_img[p];
            SR:    reg_sr    <= wr_img[p];
            CYL:   reg_cyl   <= wr_img[p];
            SL:    reg_sl    <= wr_img[p];
            TIME1: reg_time1 <= wr_img[p];
            TIME2: reg_time2 <= wr_img[p];
            EB:    eb_q      <= wr_img[p][EB_LSB +: BANK_W];
            FB:    fb_q      <= wr_img[p][FB_LSB +: BANK_W];
            BB: begin
              eb_q <= wr_img[p][EB_LSB +: BANK_W];
              fb_q <= wr_img[p][FB_LSB +: BANK_W];
            end
            // Writes to ZERO go nowhere
            default: ;
          endcase
        end
      end
    end
  end

  always_comb begin
    for (int r = 0; r < 2; r++) begin
      // Forward the post-write image, port 2 first
      if (wr_en[1] && (rs_sel[r] == wr_sel[1]) && (rs_sel[r] != ZERO)) begin
        rs_data[r] = wr_img[1];
      end else if (wr_en[0] && (rs_sel[r] == wr_sel[0]) && (rs_sel[r] != ZERO)) begin
        rs_data[r] = wr_img[0];
      end else begin
        case (rs_sel[r])
          A:     rs_data[r] = reg_a;
          L:     rs_data[r] = reg_l;
          Q:     rs_data[r] = reg_q;
          CYR:   rs_data[r] = reg_cyr;
          SR:    rs_data[r] = reg_sr;
          CYL:   rs_data[r] = reg_cyl;
          SL:    rs_data[r] = reg_sl;
          TIME1: rs_data[r] = reg_time1;
          TIME2: rs_data[r] = reg_time2;
          EB:    rs_data[r] = word_t'(eb_q) << EB_LSB;
          FB:    rs_data[r] = word_t'(fb_q) << FB_LSB;
          BB:    rs_data[r] = (word_t'(fb_q) << FB_LSB) | (word_t'(eb_q) << EB_LSB);
          default: rs_data[r] = '0;
        endcase
      end
    end
  end

  assign rs1_data = rs_data[0];
  assign rs2_data = rs_data[1];

  // Translation steers from stored bank bits only
  assign bits_eb = eb_q;
  assign bits_fb = fb_q;

endmodule

`default_nettype wire

//--- agc_regs_mem.sv
`default_nettype none

module agc_regs_mem
  import agc_pkg::*;
(
  input  logic       clk,
  input  logic       rst_l,
  input  logic       wr1_en,
  input  reg_sel_t   wr1_sel,
  input  word_t      wr1_data,
  input  logic       wr2_en,
  input  reg_sel_t   wr2_sel,
  input  word_t      wr2_data,
  input  reg_sel_t   rs1_sel,
  input  reg_sel_t   rs2_sel,
  output word_t      rs1_data,
  output word_t      rs2_data,
  input  soft_addr_t addr_pc,
  input  soft_addr_t addr_r,
  input  soft_addr_t addr_w,
  input  logic       ram_we_req,
  output rom_addr_t  addr_rom_pc,
  output rom_addr_t  addr_rom_r,
  output ram_addr_t  addr_ram_r,
  output ram_addr_t  addr_ram_w,
  output logic       ram_we
);

  // Stored bank fields into translation
  bank_t bits_eb;
  bank_t bits_fb;

  agc_register_file u_regs (
    .clk      (clk),
    .rst_l    (rst_l),
    .wr1_en   (wr1_en),
    .wr2_en   (wr2_en),
    .wr1_sel  (wr1_sel),
    .wr2_sel  (wr2_sel),
    .rs1_sel  (rs1_sel),
    .rs2_sel  (rs2_sel),
    .wr1_data (wr1_data),
    .wr2_data (wr2_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .bits_eb  (bits_eb),
    .bits_fb  (bits_fb)
  );

  agc_addr_translate u_xlate (
    .addr_pc     (addr_pc),
    .addr_r      (addr_r),
    .addr_w      (addr_w),
    .bits_eb     (bits_eb),
    .bits_fb     (bits_fb),
    .ram_we_req  (ram_we_req),
    .addr_rom_pc (addr_rom_pc),
    .addr_rom_r  (addr_rom_r),
    .addr_ram_r  (addr_ram_r),
    .addr_ram_w  (addr_ram_w),
    .ram_we      (ram_we)
  );

endmodule

`default_nettype wire

//--- tb_agc_regs_mem.sv
`default_nettype none

module tb_agc_regs_mem
  import agc_pkg::*;
;

  logic       clk;
  logic       rst_l;
  logic       wr1_en;
  logic       wr2_en;
  logic       ram_we_req;
  logic       ram_we;
  reg_sel_t   wr1_sel, wr2_sel, rs1_sel, rs2_sel;
  word_t      wr1_data, wr2_data, rs1_data, rs2_data;
  soft_addr_t addr_pc, addr_r, addr_w;
  rom_addr_t  addr_rom_pc, addr_rom_r;
  ram_addr_t  addr_ram_r, addr_ram_w;

  // Shadow register state
  word_t    model_reg [16];
  bank_t    m_eb;
  bank_t    m_fb;
  reg_sel_t prev_sel;

  reg_sel_t plain_regs [5] = '{A, L, Q, TIME1, TIME2};
  reg_sel_t edit_regs [4] = '{CYR, SR, CYL, SL};
  reg_sel_t data_regs [9] = '{A, L, Q, TIME1, TIME2, CYR, SR, CYL, SL};
  reg_sel_t bank_regs [3] = '{EB, FB, BB};

  int    n_iter = 40;
  int    errors = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    errors_at_start;
  string cur_test;

  agc_regs_mem dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset, 13 register reads, then five tests of n_iter cycles
  function automatic int planned_cycles();
    return 8 + 13 + 5 * n_iter;
  endfunction

  function automatic int pick(int n);
    return int'($urandom % 32'(n));
  endfunction

  // Value a register reads back after a write of d
  function automatic word_t readback_of(reg_sel_t sel, word_t d);
    int unsigned u;
    int unsigned r;
    u = 32'(d);
    case (sel)
      CYR: r = (u >> 1) | ((u & 32'd1) << 14);
      SR:  r = (u >> 1) | (u & 32'h4000);
      CYL: r = ((u << 1) | (u >> 14)) & 32'h7fff;
      SL:  r = (u << 1) & 32'h7fff;
      EB:  r = u & 32'o7000;
      FB:  r = u & 32'o70000;
      BB:  r = u & 32'o77000;
      ZERO: r = 0;
      default: r = u;
    endcase
    return word_t'(r);
  endfunction

  function automatic word_t stored_read(reg_sel_t sel);
    case (sel)
      ZERO: return '0;
      EB:   return word_t'(32'(m_eb) << 9);
      FB:   return word_t'(32'(m_fb) << 12);
      BB:   return word_t'((32'(m_fb) << 12) | (32'(m_eb) << 9));
      default: return model_reg[sel];
    endcase
  endfunction

  function automatic word_t expected_read(reg_sel_t sel);
    if (sel != ZERO && wr2_en && wr2_sel == sel) return readback_of(sel, wr2_data);
    if (sel != ZERO && wr1_en && wr1_sel == sel) return readback_of(sel, wr1_data);
    return stored_read(sel);
  endfunction

  function automatic rom_addr_t rom_expect(soft_addr_t a, bank_t fb);
    int unsigned ua;
    ua = 32'(a);
    if (ua >= 32'o4000) return rom_addr_t'(ua - 32'o4000);
    return rom_addr_t'(ua + 32'o2000 + 32'(fb) * 32'o2000);
  endfunction

  function automatic ram_addr_t ram_expect(soft_addr_t a, bank_t eb);
    int unsigned ua;
    int unsigned off;
    ua = 32'(a) % 32'o4000;
    off = eb[2] ? 32'o2000 : 32'(eb[1:0]) * 32'o400;
    if (32'(a) < 32'o1400) return ram_addr_t'(ua);
    return ram_addr_t'((ua + off) % 32'o4000);
  endfunction

  task automatic apply_write(reg_sel_t sel, word_t d);
    case (sel)
      EB: m_eb = d[11:9];
      FB: m_fb = d[14:12];
      BB: begin
        m_eb = d[11:9];
        m_fb = d[14:12];
      end
      ZERO: ;
      default: model_reg[sel] = readback_of(sel, d);
    endcase
  endtask

  task automatic check_value(string what, logic [15:0] exp, logic [15:0] act);
    assert (act === exp) else begin
      $display("Mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_outputs();
    logic      r_rom;
    r_rom = addr_r >= 12'o2000;
    check_value("rs1_data", 16'(expected_read(rs1_sel)), 16'(rs1_data));
    check_value("rs2_data", 16'(expected_read(rs2_sel)), 16'(rs2_data));
    check_value("addr_rom_pc", 16'(rom_expect(addr_pc, m_fb)), 16'(addr_rom_pc));
    check_value("addr_rom_r", r_rom ? 16'(rom_expect(addr_r, m_fb)) : 16'o2000,
                16'(addr_rom_r));
    check_value("addr_ram_r", r_rom ? 16'd0 : 16'(ram_expect(addr_r, m_eb)), 16'(addr_ram_r));
    check_value("addr_ram_w", 16'(ram_expect(addr_w, m_eb)), 16'(addr_ram_w));
    check_value("ram_we", 16'(ram_we_req && (addr_w < 12'o2000)), 16'(ram_we));
  endtask

  // Check mid-cycle, then mirror the edge in the model
  task automatic finish_cycle();
    @(negedge clk);
    check_outputs();
    @(posedge clk);
    if (wr1_en) apply_write(wr1_sel, wr1_data);
    if (wr2_en) apply_write(wr2_sel, wr2_data);
    #1;
  endtask

  task automatic random_addrs();
    addr_pc = soft_addr_t'($urandom);
    addr_r = soft_addr_t'($urandom);
    addr_w = soft_addr_t'($urandom);
    ram_we_req = 1'($urandom);
  endtask

  task automatic start_test(string name);
    cur_test = name;
    errors_at_start = errors;
    wr1_en = 1'b0;
    wr2_en = 1'b0;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != errors_at_start) begin
      tests_failed++;
      $display("%s: FAIL, %0d mismatches", cur_test, errors - errors_at_start);
    end else begin
      $display("%s: pass", cur_test);
    end
  endtask

  initial begin
    #(planned_cycles() * 10 + 200);
    $display("Timeout: run did not finish within %0d cycles", planned_cycles());
    $display("Errors found");
    $finish;
  end

  initial begin
    void'($urandom(32'hbbdd6fcc));
    rst_l = 1'b0;
    wr1_en = 1'b0;
    wr2_en = 1'b0;
    wr1_sel = A;
    wr2_sel = A;
    rs1_sel = A;
    rs2_sel = A;
    wr1_data = '0;
    wr2_data = '0;
    addr_pc = '0;
    addr_r = '0;
    addr_w = '0;
    ram_we_req = 1'b0;
    prev_sel = A;
    m_eb = '0;
    m_fb = '0;
    foreach (model_reg[i]) model_reg[i] = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_l = 1'b1;

    start_test("reset");
    for (int i = 0; i < 13; i++) begin
      random_addrs();
      ram_we_req = 1'b0;
      rs1_sel = reg_sel_t'(i);
      rs2_sel = reg_sel_t'(12 - i);
      finish_cycle();
    end
    end_test();

    // Port 2 keeps hitting ZERO while port 1 fills plain registers
    start_test("plain_regs");
    for (int i = 0; i < n_iter; i++) begin
      random_addrs();
      wr1_en = 1'b1;
      wr1_sel = plain_regs[pick(5)];
      wr1_data = word_t'($urandom);
      wr2_en = 1'($urandom);
      wr2_sel = ZERO;
      wr2_data = word_t'($urandom);
      rs1_sel = prev_sel;
      rs2_sel = ZERO;
      prev_sel = wr1_sel;
      finish_cycle();
    end
    end_test();

    start_test("editing_regs");
    for (int i = 0; i < n_iter; i++) begin
      random_addrs();
      wr1_en = 1'b1;
      wr1_sel = edit_regs[pick(4)];
      wr1_data = word_t'($urandom);
      rs1_sel = wr1_sel;
      rs2_sel = prev_sel;
      prev_sel = wr1_sel;
      finish_cycle();
    end
    end_test();

    start_test("dual_port");
    for (int i = 0; i < n_iter; i++) begin
      random_addrs();
      wr1_en = 1'b1;
      wr2_en = 1'b1;
      wr1_sel = data_regs[pick(9)];
      wr2_sel = wr1_sel;
      wr1_data = word_t'($urandom);
      wr2_data = word_t'($urandom);
      rs1_sel = wr1_sel;
      rs2_sel = prev_sel;
      prev_sel = wr1_sel;
      finish_cycle();
    end
    end_test();

    // Write cycles alternate with cycles that only read the stored fields
    start_test("bank_rom");
    for (int i = 0; i < n_iter; i++) begin
      random_addrs();
      wr1_en = (i % 2) == 0;
      wr1_sel = bank_regs[pick(3)];
      wr1_data = word_t'($urandom);
      rs1_sel = wr1_en ? wr1_sel : bank_regs[pick(3)];
      rs2_sel = wr1_en ? wr1_sel : bank_regs[pick(3)];
      finish_cycle();
    end
    end_test();

    start_test("ram_xlate");
    for (int e = 0; e < 8; e++) begin
      for (int i = 0; i < n_iter / 8; i++) begin
        random_addrs();
        addr_r = soft_addr_t'($urandom % 32'o2000);
        wr1_en = i == 0;
        wr1_sel = EB;
        wr1_data = word_t'($urandom);
        wr1_data[11:9] = bank_t'(e);
        rs1_sel = EB;
        rs2_sel = BB;
        finish_cycle();
      end
    end
    end_test();

    $display("Summary: %0d tests, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- agc_regs_mem.f
agc_pkg.sv
agc_rom_translate.sv
agc_ram_translate.sv
agc_addr_translate.sv
agc_register_file.sv
agc_regs_mem.sv
tb_agc_regs_mem.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_agc_regs_mem -f agc_regs_mem.f -o sim_tb || exit 1
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "No errors" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
